/* tb.f */
hw/cpuPkg.sv
hw/dpControlIf.sv
hw/addrControlIf.sv
hw/aluUnit.sv
hw/datapath.sv
hw/addressUnit.sv
hw/controlSequencer.sv
hw/cpuCore.sv
sim/tbCpuCore.sv

/* Makefile */
# Verilator build and run of the 6502 subset core testbench
TOP := tbCpuCore
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tbCpuCore.sv */
// testbench for the 6502 subset core
// memory model, reference interpreter, stream checks and report
module tbCpuCore;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [cpuPkg::addrWidth-1:0] startPc = 16'h0300;
  // self loop that marks the end of a program
  localparam logic [cpuPkg::addrWidth-1:0] endPc = 16'h0F00;
  localparam int runLimit = 2000;

  logic                         phi0;
  logic                         reset;
  logic [cpuPkg::dataWidth-1:0] dataIn;
  logic [cpuPkg::addrWidth-1:0] addr;
  logic [cpuPkg::dataWidth-1:0] dataOut;
  logic                         rw;
  logic                         sync;

  logic [cpuPkg::dataWidth-1:0] mem [0:65535];
  logic [cpuPkg::dataWidth-1:0] refMem [0:65535];
  logic [cpuPkg::dataWidth-1:0] prog [$];

  // expected and observed streams
  logic [cpuPkg::addrWidth-1:0] expWrAddr [$];
  logic [cpuPkg::dataWidth-1:0] expWrData [$];
  logic [cpuPkg::addrWidth-1:0] expSync [$];
  int                           expCycles [$];
  logic [cpuPkg::addrWidth-1:0] gotWrAddr [$];
  logic [cpuPkg::dataWidth-1:0] gotWrData [$];
  logic [cpuPkg::addrWidth-1:0] gotSync [$];
  int                           gotCycles [$];

  int cycleCount;
  bit runDone;
  bit rwLowInReset;
  int testErrors;
  int errors;
  int testsRun;
  int testsFailed;

  cpuCore #(
    .resetPc (startPc)
  ) u_cpuCore (
    .phi0    (phi0),
    .reset   (reset),
    .dataIn  (dataIn),
    .addr    (addr),
    .dataOut (dataOut),
    .rw      (rw),
    .sync    (sync)
  );

  always #5 phi0 = ~phi0;

  // asynchronous read, write at the edge ending a low rw cycle
  assign dataIn = mem[addr];

  always @(posedge phi0) begin
    if (!rw) mem[addr] <= dataOut;
  end

  // monitor mid cycle, where the bus is settled
  always @(negedge phi0) begin
    if (reset) begin
      if (!rw) rwLowInReset = 1'b1;
    end else if (!runDone) begin
      if (!rw) begin
        gotWrAddr.push_back(addr);
        gotWrData.push_back(dataOut);
      end
      if (sync) begin
        // length of the instruction that just ended
        if (gotSync.size() > 0) gotCycles.push_back(cycleCount);
        gotSync.push_back(addr);
        cycleCount = 1;
        if (addr == endPc) runDone = 1'b1;
      end else begin
        cycleCount = cycleCount + 1;
      end
    end
  end

  // group one immediate opcode built from its fields
  function automatic logic [cpuPkg::dataWidth-1:0] groupOneImm(logic [2:0] aaa);
    cpuPkg::opcodeU op;
    op.fields.aaa = aaa;
    op.fields.bbb = cpuPkg::modeImm;
    op.fields.cc  = cpuPkg::grpOne;
    return op.raw;
  endfunction

  function automatic logic [cpuPkg::dataWidth-1:0] randomByte();
    return 8'($urandom());
  endfunction

  task automatic implied(logic [cpuPkg::dataWidth-1:0] op);
    prog.push_back(op);
  endtask

  // immediate operand or zero page address
  task automatic withByte(logic [cpuPkg::dataWidth-1:0] op, logic [cpuPkg::dataWidth-1:0] b);
    prog.push_back(op);
    prog.push_back(b);
  endtask

  task automatic jumpTo(logic [cpuPkg::addrWidth-1:0] target);
    prog.push_back(cpuPkg::opJmpAbs);
    prog.push_back(target[7:0]);
    prog.push_back(target[15:8]);
  endtask

  // instruction level model over refMem, fills the expected streams
  function automatic void predictRun();
    logic [15:0] pc;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  op;
    logic [7:0]  m;
    logic [7:0]  st;
    int          wide;
    logic        c;
    int          cycles;
    int          steps;
    bit          finished;
    pc = startPc;
    a = 8'h00;
    x = 8'h00;
    y = 8'h00;
    c = 1'b0;
    steps = 0;
    finished = 1'b0;
    expWrAddr.delete();
    expWrData.delete();
    expSync.delete();
    expCycles.delete();
    while (!finished && steps < 500) begin
      op = refMem[pc];
      m = refMem[pc + 16'd1];
      expSync.push_back(pc);
      steps++;
      if (pc == endPc) begin
        finished = 1'b1;
      end else begin
        cycles = 2;
        case (op)
          8'hA9: begin a = m; pc = pc + 16'd2; end
          8'hA2: begin x = m; pc = pc + 16'd2; end
          8'hA0: begin y = m; pc = pc + 16'd2; end
          8'h69: begin
            // carry out once the sum passes ff
            wide = int'(a) + int'(m) + int'(c);
            a = wide[7:0];
            c = (wide > 255);
            pc = pc + 16'd2;
          end
          8'hE9: begin
            // clear carry borrows one more
            // carry set afterwards when nothing was borrowed
            wide = int'(a) - int'(m) - ((c == 1'b1) ? 0 : 1);
            a = wide[7:0];
            c = (wide >= 0);
            pc = pc + 16'd2;
          end
          8'h29: begin a = a & m; pc = pc + 16'd2; end
          8'h09: begin a = a | m; pc = pc + 16'd2; end
          8'h49: begin a = a ^ m; pc = pc + 16'd2; end
          8'hAA: begin x = a; pc = pc + 16'd1; end
          8'hA8: begin y = a; pc = pc + 16'd1; end
          8'h8A: begin a = x; pc = pc + 16'd1; end
          8'h98: begin a = y; pc = pc + 16'd1; end
          8'hE8: begin x = x + 8'd1; pc = pc + 16'd1; end
          8'hC8: begin y = y + 8'd1; pc = pc + 16'd1; end
          8'hCA: begin x = x - 8'd1; pc = pc + 16'd1; end
          8'h88: begin y = y - 8'd1; pc = pc + 16'd1; end
          8'h18: begin c = 1'b0; pc = pc + 16'd1; end
          8'h38: begin c = 1'b1; pc = pc + 16'd1; end
          8'h85, 8'h86, 8'h84: begin
            st = (op == 8'h85) ? a : ((op == 8'h86) ? x : y);
            refMem[{8'h00, m}] = st;
            expWrAddr.push_back({8'h00, m});
            expWrData.push_back(st);
            pc = pc + 16'd2;
            cycles = 3;
          end
          8'h4C: begin
            pc = {refMem[pc + 16'd2], m};
            cycles = 3;
          end
          // anything else is a one byte no-op
          default: pc = pc + 16'd1;
        endcase
        expCycles.push_back(cycles);
      end
    end
  endfunction

  task automatic checkAddr(string name, logic [cpuPkg::addrWidth-1:0] got,
                           logic [cpuPkg::addrWidth-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkData(string name, logic [cpuPkg::dataWidth-1:0] got,
                           logic [cpuPkg::dataWidth-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkCycles(string name, int got, int exp);
    if (got != exp) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
      testErrors++;
    end
  endtask

  // load prog at startPc, reset, run to endPc, compare the streams
  task runProgram(string title);
    int waitCycles;
    int i;
    testErrors = 0;
    jumpTo(endPc);
    @(posedge phi0);
    reset <= 1'b1;
    for (i = 0; i < prog.size(); i++) mem[startPc + i] <= prog[i];
    mem[endPc] <= cpuPkg::opJmpAbs;
    mem[endPc + 1] <= endPc[7:0];
    mem[endPc + 2] <= endPc[15:8];
    rwLowInReset = 1'b0;
    runDone = 1'b0;
    gotWrAddr.delete();
    gotWrData.delete();
    gotSync.delete();
    gotCycles.delete();
    @(posedge phi0);
    refMem = mem;
    predictRun();
    repeat (7) @(posedge phi0);
    reset <= 1'b0;
    waitCycles = 0;
    while (!runDone && waitCycles < runLimit) begin
      @(posedge phi0);
      waitCycles++;
    end
    if (!runDone) begin
      $display("Error: %s never fetched the end address %h", title, endPc);
      testErrors++;
    end else begin
      if (rwLowInReset) begin
        $display("Error: %s saw rw low while reset was held", title);
        testErrors++;
      end
      if (gotSync.size() > 0) checkAddr("addr (first sync)", gotSync[0], startPc);
      if (gotSync.size() != expSync.size() || gotCycles.size() != expCycles.size()) begin
        $display("Error: %s fetched %0d instructions, model expects %0d", title,
                 gotSync.size(), expSync.size());
        testErrors++;
      end else begin
        for (i = 0; i < expSync.size(); i++)
          checkAddr($sformatf("addr (sync %0d)", i), gotSync[i], expSync[i]);
        for (i = 0; i < expCycles.size(); i++)
          checkCycles($sformatf("cycles (instr %0d)", i), gotCycles[i], expCycles[i]);
      end
      if (gotWrAddr.size() != expWrAddr.size()) begin
        $display("Error: %s made %0d writes, model expects %0d", title,
                 gotWrAddr.size(), expWrAddr.size());
        testErrors++;
      end else begin
        for (i = 0; i < expWrAddr.size(); i++) begin
          checkAddr($sformatf("addr (write %0d)", i), gotWrAddr[i], expWrAddr[i]);
          checkData($sformatf("dataOut (write %0d)", i), gotWrData[i], expWrData[i]);
        end
      end
    end
    testsRun++;
    if (testErrors > 0) testsFailed++;
    errors += testErrors;
    $display("test %s: %s, %0d errors", title, (testErrors == 0) ? "ok" : "failed",
             testErrors);
    prog.delete();
  endtask

  initial begin
    logic [7:0] groupOps [5];
    int k;
    phi0 = 1'b0;
    reset = 1'b1;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    cycleCount = 0;
    runDone = 1'b0;
    rwLowInReset = 1'b0;
    void'($urandom(12724));
    // background fill, varies with both address bytes
    for (k = 0; k < 65536; k++) mem[k] = k[15:8] ^ k[7:0] ^ 8'hA5;
    groupOps[0] = groupOneImm(cpuPkg::grpAdc);
    groupOps[1] = groupOneImm(cpuPkg::grpSbc);
    groupOps[2] = groupOneImm(cpuPkg::grpAnd);
    groupOps[3] = groupOneImm(cpuPkg::grpOra);
    groupOps[4] = groupOneImm(cpuPkg::grpEor);

    // first fetch after reset
    withByte(cpuPkg::opLdaImm, 8'h5A);
    withByte(cpuPkg::opStaZp, 8'h10);
    runProgram("reset");

    withByte(cpuPkg::opLdaImm, randomByte());
    withByte(cpuPkg::opLdxImm, randomByte());
    withByte(cpuPkg::opLdyImm, randomByte());
    withByte(cpuPkg::opStaZp, 8'h20);
    withByte(cpuPkg::opStxZp, 8'h21);
    withByte(cpuPkg::opStyZp, 8'h22);
    runProgram("loads and stores");

    // second adc shows the carry left behind
    for (k = 0; k < 10; k++) begin
      implied(($urandom() % 2 == 0) ? cpuPkg::opClc : cpuPkg::opSec);
      withByte(cpuPkg::opLdaImm, randomByte());
      withByte(groupOps[k % 5], randomByte());
      withByte(cpuPkg::opStaZp, 8'(8'h30 + k));
      withByte(groupOps[0], randomByte());
      withByte(cpuPkg::opStaZp, 8'(8'h40 + k));
    end
    runProgram("alu");

    // wraparound both ways, plus an unknown opcode
    withByte(cpuPkg::opLdxImm, 8'hFF);
    implied(cpuPkg::opInx);
    withByte(cpuPkg::opStxZp, 8'h50);
    implied(cpuPkg::opDex);
    withByte(cpuPkg::opStxZp, 8'h51);
    withByte(cpuPkg::opLdyImm, 8'h00);
    implied(cpuPkg::opDey);
    withByte(cpuPkg::opStyZp, 8'h52);
    implied(cpuPkg::opIny);
    withByte(cpuPkg::opStyZp, 8'h53);
    withByte(cpuPkg::opLdaImm, randomByte());
    implied(cpuPkg::opTax);
    implied(cpuPkg::opTay);
    implied(cpuPkg::opInx);
    implied(cpuPkg::opDey);
    implied(8'hEA);
    implied(cpuPkg::opTxa);
    withByte(cpuPkg::opStaZp, 8'h54);
    implied(cpuPkg::opTya);
    withByte(cpuPkg::opStaZp, 8'h55);
    runProgram("transfers and steps");

    // jump over padding to the next page
    jumpTo(16'h0400);
    while (prog.size() < 256) prog.push_back(8'hEA);
    withByte(cpuPkg::opLdaImm, randomByte());
    withByte(cpuPkg::opStaZp, 8'h60);
    runProgram("jump");

    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* hw/cpuCore.sv */
// 6502 subset core top level
// sequencer, address unit and datapath
module cpuCore #(
  parameter logic [cpuPkg::addrWidth-1:0] resetPc = 16'h0200
) (
  input  logic                          phi0,
  input  logic                          reset,
  input  logic [cpuPkg::dataWidth-1:0]  dataIn,
  output logic [cpuPkg::addrWidth-1:0]  addr,
  output logic [cpuPkg::dataWidth-1:0]  dataOut,
  output logic                          rw,
  output logic                          sync
);

  // control bundles between the blocks
  dpControlIf   dpCtl ();
  addrControlIf addrCtl ();

  controlSequencer u_controlSequencer (
    .phi0   (phi0),
    .reset  (reset),
    .dataIn (dataIn),
    .dp     (dpCtl.control),
    .ac     (addrCtl.control),
    .rw     (rw),
    .sync   (sync)
  );

  // start address passed down
  addressUnit #(
    .resetPc (resetPc)
  ) u_addressUnit (
    .phi0   (phi0),
    .reset  (reset),
    .dataIn (dataIn),
    .ac     (addrCtl.address),
    .addr   (addr)
  );

  datapath u_datapath (
    .phi0    (phi0),
    .reset   (reset),
    .dataIn  (dataIn),
    .dp      (dpCtl.datapath),
    .dataOut (dataOut)
  );

endmodule

/* hw/controlSequencer.sv */
// cycle counter, opcode register and decode
// drives datapath and address control, rw and sync
module controlSequencer (
  input  logic                         phi0,
  input  logic                         reset,
  input  logic [cpuPkg::dataWidth-1:0] dataIn,
  dpControlIf.control                  dp,
  addrControlIf.control                ac,
  output logic                         rw,
  output logic                         sync
);

  localparam logic [1:0] cycT0 = 2'd0;
  localparam logic [1:0] cycT1 = 2'd1;
  localparam logic [1:0] cycT2 = 2'd2;

  logic [1:0]    cycle;
  logic [1:0]    nextCycle;
  cpuPkg::opcodeU opReg;
  logic          isStore;
  logic          isJmp;
  logic [1:0]    storeSrc;
  logic          grpValid;
  logic [2:0]    grpAluOp;
  logic          grpCarry;

  // zero page stores and absolute jump need a third cycle
  assign isStore = (opReg.raw == cpuPkg::opStaZp) || (opReg.raw == cpuPkg::opStxZp) ||
                   (opReg.raw == cpuPkg::opStyZp);
  assign isJmp   = (opReg.raw == cpuPkg::opJmpAbs);

  // register put on the bus during a store
  always_comb begin
    storeSrc = cpuPkg::srcA;
    if (opReg.raw == cpuPkg::opStxZp) storeSrc = cpuPkg::srcX;
    else if (opReg.raw == cpuPkg::opStyZp) storeSrc = cpuPkg::srcY;
  end

  // group one immediate decode by fields
  always_comb begin
    grpValid = 1'b0;
    grpAluOp = cpuPkg::aluPass;
    grpCarry = 1'b0;
    if (opReg.fields.cc == cpuPkg::grpOne && opReg.fields.bbb == cpuPkg::modeImm) begin
      grpValid = 1'b1;
      case (opReg.fields.aaa)
        cpuPkg::grpOra: grpAluOp = cpuPkg::aluOra;
        cpuPkg::grpAnd: grpAluOp = cpuPkg::aluAnd;
        cpuPkg::grpEor: grpAluOp = cpuPkg::aluEor;
        cpuPkg::grpLda: grpAluOp = cpuPkg::aluPass;
        cpuPkg::grpAdc: begin
          grpAluOp = cpuPkg::aluAdc;
          grpCarry = 1'b1;
        end
        cpuPkg::grpSbc: begin
          grpAluOp = cpuPkg::aluSbc;
          grpCarry = 1'b1;
        end
        // sta imm and cmp imm fall through as no-ops
        default: grpValid = 1'b0;
      endcase
    end
  end

  // per cycle control
  always_comb begin
    dp.busSrc     = cpuPkg::srcData;
    dp.aluOp      = cpuPkg::aluPass;
    dp.loadA      = 1'b0;
    dp.loadX      = 1'b0;
    dp.loadY      = 1'b0;
    dp.carryWrite = 1'b0;
    dp.carrySet   = 1'b0;
    dp.carryClear = 1'b0;
    ac.incPc      = 1'b0;
    ac.latchLow   = 1'b0;
    ac.jumpPc     = 1'b0;
    ac.zpCycle    = 1'b0;
    rw            = 1'b1;
    sync          = 1'b0;
    nextCycle     = cycT0;
    case (cycle)
      cycT0: begin
        // opcode fetch
        sync      = 1'b1;
        ac.incPc  = 1'b1;
        nextCycle = cycT1;
      end
      cycT1: begin
        nextCycle = (isStore || isJmp) ? cycT2 : cycT0;
        case (opReg.raw)
          cpuPkg::opLdxImm: begin
            ac.incPc = 1'b1;
            dp.loadX = 1'b1;
          end
          cpuPkg::opLdyImm: begin
            ac.incPc = 1'b1;
            dp.loadY = 1'b1;
          end
          // transfers, pc holds for the dummy read
          cpuPkg::opTax: begin
            dp.busSrc = cpuPkg::srcA;
            dp.loadX  = 1'b1;
          end
          cpuPkg::opTay: begin
            dp.busSrc = cpuPkg::srcA;
            dp.loadY  = 1'b1;
          end
          cpuPkg::opTxa: begin
            dp.busSrc = cpuPkg::srcX;
            dp.loadA  = 1'b1;
          end
          cpuPkg::opTya: begin
            dp.busSrc = cpuPkg::srcY;
            dp.loadA  = 1'b1;
          end
          cpuPkg::opInx, cpuPkg::opDex: begin
            dp.busSrc = cpuPkg::srcX;
            dp.aluOp  = (opReg.raw == cpuPkg::opInx) ? cpuPkg::aluInc : cpuPkg::aluDec;
            dp.loadX  = 1'b1;
          end
          cpuPkg::opIny, cpuPkg::opDey: begin
            dp.busSrc = cpuPkg::srcY;
            dp.aluOp  = (opReg.raw == cpuPkg::opIny) ? cpuPkg::aluInc : cpuPkg::aluDec;
            dp.loadY  = 1'b1;
          end
          cpuPkg::opClc: dp.carryClear = 1'b1;
          cpuPkg::opSec: dp.carrySet = 1'b1;
          // operand byte, zp address or jump low byte
          cpuPkg::opStaZp, cpuPkg::opStxZp, cpuPkg::opStyZp, cpuPkg::opJmpAbs: begin
            ac.incPc    = 1'b1;
            ac.latchLow = 1'b1;
          end
          default: begin
            if (grpValid) begin
              ac.incPc      = 1'b1;
              dp.aluOp      = grpAluOp;
              dp.loadA      = 1'b1;
              dp.carryWrite = grpCarry;
            end
          end
        endcase
      end
      cycT2: begin
        if (isStore) begin
          ac.zpCycle = 1'b1;
          dp.busSrc  = storeSrc;
          rw         = 1'b0;
        end
        // high byte read at pc, target taken at cycle end
        ac.jumpPc = isJmp;
      end
      default: nextCycle = cycT0;
    endcase
  end

  always_ff @(posedge phi0) begin
    if (reset) begin
      cycle <= cycT0;
    end else begin
      cycle <= nextCycle;
    end
  end

  // opcode captured at the end of the fetch
  always_ff @(posedge phi0) begin
    if (cycle == cycT0) begin
      opReg.raw <= dataIn;
    end
  end

  // a write follows an operand latch one cycle earlier
  assert property (@(posedge phi0) disable iff (reset)
    !rw |-> (cycle == cycT2) && isStore && $past(ac.latchLow));

endmodule

/* hw/addressUnit.sv */
// program counter, operand low byte latch, address mux
module addressUnit #(
  parameter logic [cpuPkg::addrWidth-1:0] resetPc = 16'h0200
) (
  input  logic                         phi0,
  input  logic                         reset,
  input  logic [cpuPkg::dataWidth-1:0] dataIn,
  addrControlIf.address                ac,
  output logic [cpuPkg::addrWidth-1:0] addr
);

  logic [cpuPkg::addrWidth-1:0] pc;
  logic [cpuPkg::dataWidth-1:0] lowByte;
  logic [cpuPkg::addrWidth-1:0] zpAddr;

  // pc: jump wins over step
  always_ff @(posedge phi0) begin
    if (reset) begin
      pc <= resetPc;
    end else if (ac.jumpPc) begin
      // high byte comes straight off the bus
      pc <= {dataIn, lowByte};
    end else if (ac.incPc) begin
      pc <= pc + 1'b1;
    end
  end

  // operand low byte
  always_ff @(posedge phi0) begin
    if (ac.latchLow) begin
      lowByte <= dataIn;
    end
  end

  // page zero plus latched byte
  assign zpAddr = {{(cpuPkg::addrWidth - cpuPkg::dataWidth){1'b0}}, lowByte};

  assign addr = ac.zpCycle ? zpAddr : pc;

  // sequencer never steps and jumps in one cycle
  assert property (@(posedge phi0) disable iff (reset)
    !(ac.incPc && ac.jumpPc));

endmodule

/* hw/datapath.sv */
// A, X, Y registers, carry flag and internal bus
// bus feeds the alu and doubles as store data
module datapath (
  input  logic                         phi0,
  input  logic                         reset,
  input  logic [cpuPkg::dataWidth-1:0] dataIn,
  dpControlIf.datapath                 dp,
  output logic [cpuPkg::dataWidth-1:0] dataOut
);

  logic [cpuPkg::dataWidth-1:0] regA;
  logic [cpuPkg::dataWidth-1:0] regX;
  logic [cpuPkg::dataWidth-1:0] regY;
  logic                         carry;
  logic [cpuPkg::dataWidth-1:0] bus;
  logic [cpuPkg::dataWidth-1:0] aluResult;
  logic                         aluCarry;

  // internal bus mux
  always_comb begin
    case (dp.busSrc)
      cpuPkg::srcA: bus = regA;
      cpuPkg::srcX: bus = regX;
      cpuPkg::srcY: bus = regY;
      default:      bus = dataIn;
    endcase
  end

  // accumulator is always operand A
  aluUnit u_aluUnit (
    .operation (dp.aluOp),
    .operandA  (regA),
    .operandB  (bus),
    .carryIn   (carry),
    .result    (aluResult),
    .carryOut  (aluCarry)
  );

  // register writes at the end of T1
  always_ff @(posedge phi0) begin
    if (reset) begin
      regA <= '0;
      regX <= '0;
      regY <= '0;
    end else begin
      if (dp.loadA) regA <= aluResult;
      if (dp.loadX) regX <= aluResult;
      if (dp.loadY) regY <= aluResult;
    end
  end

  // carry: sec/clc, else alu carry on adc and sbc
  always_ff @(posedge phi0) begin
    if (reset) begin
      carry <= 1'b0;
    end else if (dp.carrySet) begin
      carry <= 1'b1;
    end else if (dp.carryClear) begin
      carry <= 1'b0;
    end else if (dp.carryWrite) begin
      carry <= aluCarry;
    end
  end

  // store data, register picked by busSrc
  assign dataOut = bus;

  // one destination register per instruction
  assert property (@(posedge phi0) disable iff (reset)
    $onehot0({dp.loadA, dp.loadX, dp.loadY}));

endmodule

/* hw/aluUnit.sv */
// combinational alu: add, subtract, logic ops, inc/dec
module aluUnit (
  input  logic [2:0]                   operation,
  input  logic [cpuPkg::dataWidth-1:0] operandA,
  input  logic [cpuPkg::dataWidth-1:0] operandB,
  input  logic                         carryIn,
  output logic [cpuPkg::dataWidth-1:0] result,
  output logic                         carryOut
);

  logic [cpuPkg::dataWidth:0] sum;

  always_comb begin
    // carry passes through unless adding
    carryOut = carryIn;
    sum      = '0;
    case (operation)
      cpuPkg::aluAdc: begin
        sum      = {1'b0, operandA} + {1'b0, operandB} +
                   {{cpuPkg::dataWidth{1'b0}}, carryIn};
        result   = sum[cpuPkg::dataWidth-1:0];
        carryOut = sum[cpuPkg::dataWidth];
      end
      cpuPkg::aluSbc: begin
        // A + ~B + C, carry out set means no borrow
        sum      = {1'b0, operandA} + {1'b0, ~operandB} +
                   {{cpuPkg::dataWidth{1'b0}}, carryIn};
        result   = sum[cpuPkg::dataWidth-1:0];
        carryOut = sum[cpuPkg::dataWidth];
      end
      cpuPkg::aluAnd: result = operandA & operandB;
      cpuPkg::aluOra: result = operandA | operandB;
      cpuPkg::aluEor: result = operandA ^ operandB;
      // inc and dec wrap, flags untouched
      cpuPkg::aluInc: result = operandB + 1'b1;
      cpuPkg::aluDec: result = operandB - 1'b1;
      default:        result = operandB;
    endcase
  end

endmodule

/* hw/addrControlIf.sv */
// program counter and address bus control from the sequencer
interface addrControlIf;

  // pc step
  logic incPc;
  // operand low byte capture
  logic latchLow;
  // pc load from {dataIn, low byte}
  logic jumpPc;
  // page zero address on the bus
  logic zpCycle;

  modport control (output incPc, latchLow, jumpPc, zpCycle);
  modport address (input incPc, latchLow, jumpPc, zpCycle);

endinterface

/* hw/dpControlIf.sv */
// datapath control from the sequencer
interface dpControlIf;

  // internal bus source and alu operation
  logic [1:0] busSrc;
  logic [2:0] aluOp;
  // register write enables
  logic       loadA;
  logic       loadX;
  logic       loadY;
  // carry flag updates
  logic       carryWrite;
  logic       carrySet;
  logic       carryClear;

  modport control (output busSrc, aluOp, loadA, loadX, loadY, carryWrite, carrySet,
                   carryClear);
  modport datapath (input busSrc, aluOp, loadA, loadX, loadY, carryWrite, carrySet,
                    carryClear);

endinterface

/* hw/cpuPkg.sv */
// shared widths, opcode values, alu and bus select codes
// opcode union viewed raw or as aaa/bbb/cc fields
package cpuPkg;

  localparam int dataWidth = 8;
  localparam int addrWidth = 16;

  // standard 6502 opcode bytes of the supported subset
  localparam logic [dataWidth-1:0] opLdaImm = 8'hA9;
  localparam logic [dataWidth-1:0] opLdxImm = 8'hA2;
  localparam logic [dataWidth-1:0] opLdyImm = 8'hA0;
  localparam logic [dataWidth-1:0] opTax    = 8'hAA;
  localparam logic [dataWidth-1:0] opTay    = 8'hA8;
  localparam logic [dataWidth-1:0] opTxa    = 8'h8A;
  localparam logic [dataWidth-1:0] opTya    = 8'h98;
  localparam logic [dataWidth-1:0] opInx    = 8'hE8;
  localparam logic [dataWidth-1:0] opIny    = 8'hC8;
  localparam logic [dataWidth-1:0] opDex    = 8'hCA;
  localparam logic [dataWidth-1:0] opDey    = 8'h88;
  localparam logic [dataWidth-1:0] opClc    = 8'h18;
  localparam logic [dataWidth-1:0] opSec    = 8'h38;
  localparam logic [dataWidth-1:0] opStaZp  = 8'h85;
  localparam logic [dataWidth-1:0] opStxZp  = 8'h86;
  localparam logic [dataWidth-1:0] opStyZp  = 8'h84;
  localparam logic [dataWidth-1:0] opJmpAbs = 8'h4C;

  // group one: aaa selects the operation
  localparam logic [2:0] grpOra = 3'b000;
  localparam logic [2:0] grpAnd = 3'b001;
  localparam logic [2:0] grpEor = 3'b010;
  localparam logic [2:0] grpAdc = 3'b011;
  localparam logic [2:0] grpLda = 3'b101;
  localparam logic [2:0] grpSbc = 3'b111;
  localparam logic [1:0] grpOne  = 2'b01;
  localparam logic [2:0] modeImm = 3'b010;

  // alu operations
  localparam logic [2:0] aluPass = 3'd0;
  localparam logic [2:0] aluAdc  = 3'd1;
  localparam logic [2:0] aluSbc  = 3'd2;
  localparam logic [2:0] aluAnd  = 3'd3;
  localparam logic [2:0] aluOra  = 3'd4;
  localparam logic [2:0] aluEor  = 3'd5;
  localparam logic [2:0] aluInc  = 3'd6;
  localparam logic [2:0] aluDec  = 3'd7;

  // internal bus sources
  localparam logic [1:0] srcData = 2'd0;
  localparam logic [1:0] srcA    = 2'd1;
  localparam logic [1:0] srcX    = 2'd2;
  localparam logic [1:0] srcY    = 2'd3;

  typedef union packed {
    logic [dataWidth-1:0] raw;
    struct packed {
      logic [2:0] aaa;
      logic [2:0] bbb;
      logic [1:0] cc;
    } fields;
  } opcodeU;

endpackage
